/* eeprom_if.f */
src/eeprom_pkg.sv
src/i2c_byte_engine.sv
src/eeprom_ctrl.sv
src/eeprom_if_top.sv
dv/i2c_eeprom_model.sv
dv/tb_eeprom_if.sv

/* Makefile */
TOP := tb_eeprom_if

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) \
		-f eeprom_if.f -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* dv/tb_eeprom_if.sv */
module tb_eeprom_if;
    timeunit 1ns;
    timeprecision 1ps;
    import eeprom_pkg::*;

    localparam int CLK_DIV     = 2;
    localparam int NUM_STIM    = 13;
    localparam int ACK_TIMEOUT = 5000;
    localparam int HOLD_CYCLES = 3;

    typedef struct packed {
        logic         write;
        eeprom_addr_t addr;
        logic [7:0]   data;
        logic         rnd_data;     // data replaced by a random byte
        logic         force_nack;
        logic         exp_error;
    } stim_t;

    logic        CLK;
    logic        RESET;
    logic        host_req;
    eeprom_cmd_t host_cmd;
    logic        host_ack;
    eeprom_rsp_t host_rsp;
    logic        scl;
    logic        sda_oe;
    logic        model_sda_oe;
    logic        sda;
    logic        force_nack;
    logic        protocol_error;
    stim_t       stim [NUM_STIM];
    logic [7:0]  ref_mem [2048];
    integer      seed;

    assign sda = !sda_oe && !model_sda_oe;  // wired-AND line

    eeprom_if_top #(.CLK_DIV(CLK_DIV)) eeprom_if_top_inst (
        .CLK(CLK), .RESET(RESET), .host_req(host_req), .host_cmd(host_cmd),
        .host_ack(host_ack), .host_rsp(host_rsp), .scl(scl), .sda_oe(sda_oe), .sda_in(sda)
    );

    i2c_eeprom_model i2c_eeprom_model_inst (
        .CLK(CLK), .RESET(RESET), .scl(scl), .sda(sda), .force_nack(force_nack),
        .sda_oe(model_sda_oe), .protocol_error(protocol_error)
    );

    initial CLK = 1'b0;
    always #4 CLK = ~CLK;

    task automatic abort_run(input string msg);
        $display("ERROR: %s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    task automatic wait_ack_level(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (host_ack !== level) begin
            @(posedge CLK);
            cycles++;
            if (cycles > ACK_TIMEOUT)
                abort_run(what);
        end
    endtask

    task automatic expect_bus_idle();
        compare_value("scl", 32'(scl), 32'd1);
        compare_value("sda_oe", 32'(sda_oe), 32'd0);
    endtask

    task automatic check_response(input stim_t s, input logic [7:0] exp_rdata);
        compare_value("host_rsp.error", 32'(host_rsp.error), 32'(s.exp_error));
        if (!s.write && !s.exp_error)
            compare_value("host_rsp.rdata", 32'(host_rsp.rdata), 32'(exp_rdata));
    endtask

    task automatic load_table();
        // write, addr, data, rnd_data, force_nack, exp_error
        stim[0]  = '{1'b0, 11'h123, 8'h00, 1'b0, 1'b0, 1'b0};   // blank so reads FF
        stim[1]  = '{1'b1, 11'h123, 8'hA5, 1'b0, 1'b0, 1'b0};
        stim[2]  = '{1'b0, 11'h123, 8'h00, 1'b0, 1'b0, 1'b0};
        stim[3]  = '{1'b1, 11'h023, 8'h00, 1'b1, 1'b0, 1'b0};   // same low byte
        stim[4]  = '{1'b1, 11'h723, 8'h00, 1'b1, 1'b0, 1'b0};
        stim[5]  = '{1'b0, 11'h023, 8'h00, 1'b0, 1'b0, 1'b0};
        stim[6]  = '{1'b0, 11'h723, 8'h00, 1'b0, 1'b0, 1'b0};
        stim[7]  = '{1'b0, 11'h323, 8'h00, 1'b0, 1'b0, 1'b0};
        stim[8]  = '{1'b1, 11'h123, 8'h5A, 1'b0, 1'b1, 1'b1};   // refused device byte
        stim[9]  = '{1'b0, 11'h123, 8'h00, 1'b0, 1'b1, 1'b1};
        stim[10] = '{1'b0, 11'h123, 8'h00, 1'b0, 1'b0, 1'b0};   // still A5
        stim[11] = '{1'b1, 11'h7FF, 8'h00, 1'b1, 1'b0, 1'b0};
        stim[12] = '{1'b0, 11'h7FF, 8'h00, 1'b0, 1'b0, 1'b0};
    endtask

    task automatic run_transaction(input int idx);
        stim_t       s;
        eeprom_cmd_t cmd;
        logic [7:0]  exp_rdata;
        s         = stim[idx];
        cmd.write = s.write;
        cmd.addr  = s.addr;
        cmd.wdata = s.rnd_data ? 8'($random(seed)) : s.data;
        exp_rdata = ref_mem[s.addr];
        @(posedge CLK);
        host_cmd   <= cmd;
        force_nack <= s.force_nack;
        host_req   <= 1'b1;
        wait_ack_level(1'b1, "timeout waiting for host_ack to rise");
        check_response(s, exp_rdata);
        expect_bus_idle();
        repeat (HOLD_CYCLES) begin
            @(posedge CLK);
            compare_value("host_ack", 32'(host_ack), 32'd1);  // held by host_req
            check_response(s, exp_rdata);
            expect_bus_idle();
        end
        if (s.write && !s.exp_error)
            ref_mem[s.addr] = cmd.wdata;
        host_req <= 1'b0;
        wait_ack_level(1'b0, "timeout waiting for host_ack to fall");
        expect_bus_idle();
    endtask

    initial begin
        seed       = 26;
        RESET      = 1'b1;
        host_req   = 1'b0;
        host_cmd   = '0;
        force_nack = 1'b0;
        for (int i = 0; i < 2048; i++)
            ref_mem[i] = 8'hFF;
        load_table();
        repeat (10) @(posedge CLK);
        RESET <= 1'b0;
        @(posedge CLK);
        compare_value("host_ack", 32'(host_ack), 32'd0);
        expect_bus_idle();
        for (int i = 0; i < NUM_STIM; i++)
            run_transaction(i);
        compare_value("protocol_error", 32'(protocol_error), 32'd0);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* dv/i2c_eeprom_model.sv */
module i2c_eeprom_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    input  logic force_nack,
    output logic sda_oe,
    output logic protocol_error
);
    timeunit 1ns;
    timeprecision 1ps;
    import eeprom_pkg::*;

    typedef enum logic [2:0] {S_IDLE, S_DEV, S_ADDR, S_WDATA, S_RDATA, S_IGNORE} state_t;

    logic [7:0]   mem [2048];
    state_t       state;
    logic         scl_q;
    logic         sda_q;
    logic [3:0]   bit_cnt;      // 8 means acknowledge clock
    logic [7:0]   shreg;
    logic [7:0]   tx_byte;
    logic [7:0]   rx_byte;
    logic [2:0]   block;
    eeprom_addr_t ptr;
    logic         ack_pend;
    logic         scl_rise;
    logic         scl_fall;
    logic         start_cond;
    logic         stop_cond;

    assign scl_rise   = scl && !scl_q;
    assign scl_fall   = !scl && scl_q;
    assign start_cond = scl && scl_q && sda_q && !sda;
    assign stop_cond  = scl && scl_q && !sda_q && sda;
    assign rx_byte    = {shreg[6:0], sda};

    initial begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hFF;     // erased part
    end

    always @(posedge CLK) begin
        if (RESET) begin
            state          <= S_IDLE;
            scl_q          <= 1'b1;
            sda_q          <= 1'b1;
            bit_cnt        <= 4'd0;
            ack_pend       <= 1'b0;
            sda_oe         <= 1'b0;
            protocol_error <= 1'b0;
            shreg          <= 8'h00;
            tx_byte        <= 8'hFF;
            block          <= 3'd0;
            ptr            <= '0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl_rise && (sda != sda_q))
                protocol_error <= 1'b1;     // data moved with the clock edge
            if (start_cond || stop_cond) begin
                if (bit_cnt > 4'd1)
                    protocol_error <= 1'b1; // inside a byte
                bit_cnt  <= 4'd0;
                ack_pend <= 1'b0;
                sda_oe   <= 1'b0;
                state    <= start_cond ? S_DEV : S_IDLE;
            end else if (scl_rise && state != S_IDLE) begin
                if (bit_cnt == 4'd8) begin
                    bit_cnt  <= 4'd0;
                    ack_pend <= 1'b0;
                end else begin
                    shreg   <= rx_byte;
                    bit_cnt <= bit_cnt + 4'd1;
                    if (bit_cnt == 4'd7) begin
                        case (state)
                            S_DEV: begin
                                if (rx_byte[7:4] != DEVICE_CODE) begin
                                    protocol_error <= 1'b1;
                                    state          <= S_IGNORE;
                                end else if (force_nack) begin
                                    state <= S_IGNORE;  // leave sda released
                                end else begin
                                    ack_pend <= 1'b1;
                                    if (rx_byte[0]) begin
                                        state   <= S_RDATA;
                                        tx_byte <= mem[ptr];
                                    end else begin
                                        block <= rx_byte[3:1];
                                        state <= S_ADDR;
                                    end
                                end
                            end
                            S_ADDR: begin
                                ptr      <= {block, rx_byte};
                                ack_pend <= 1'b1;
                                state    <= S_WDATA;
                            end
                            S_WDATA: begin
                                mem[ptr] <= rx_byte;
                                ack_pend <= 1'b1;
                                state    <= S_IGNORE;   // no page writes
                            end
                            S_RDATA: state <= S_IGNORE;
                            default: ;
                        endcase
                    end
                end
            end else if (scl_fall) begin
                if (bit_cnt == 4'd8) begin
                    sda_oe <= ack_pend;
                end else if (state == S_RDATA) begin
                    sda_oe  <= ~tx_byte[7];
                    tx_byte <= {tx_byte[6:0], 1'b1};
                end else begin
                    sda_oe <= 1'b0;
                end
            end
        end
    end

endmodule

/* src/eeprom_if_top.sv */
module eeprom_if_top #(
    parameter int CLK_DIV = 2       // clk cycles per quarter scl period
) (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    host_req,
    input  eeprom_pkg::eeprom_cmd_t host_cmd,
    output logic                    host_ack,
    output eeprom_pkg::eeprom_rsp_t host_rsp,
    output logic                    scl,
    output logic                    sda_oe,
    input  logic                    sda_in
);
    import eeprom_pkg::*;

    logic     op_req;
    logic     op_ack;
    i2c_req_t op;
    i2c_rsp_t op_rsp;

    eeprom_ctrl eeprom_ctrl_inst (
        .CLK      (CLK),
        .RESET    (RESET),
        .host_req (host_req),
        .host_cmd (host_cmd),
        .host_ack (host_ack),
        .host_rsp (host_rsp),
        .op_req   (op_req),
        .op       (op),
        .op_ack   (op_ack),
        .op_rsp   (op_rsp)
    );

    i2c_byte_engine #(
        .CLK_DIV (CLK_DIV)
    ) i2c_byte_engine_inst (
        .CLK    (CLK),
        .RESET  (RESET),
        .op_req (op_req),
        .op     (op),
        .sda_in (sda_in),
        .op_ack (op_ack),
        .op_rsp (op_rsp),
        .scl    (scl),
        .sda_oe (sda_oe)
    );

endmodule

/* src/eeprom_ctrl.sv */
module eeprom_ctrl (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    host_req,
    input  eeprom_pkg::eeprom_cmd_t host_cmd,
    output logic                    host_ack,
    output eeprom_pkg::eeprom_rsp_t host_rsp,
    output logic                    op_req,
    output eeprom_pkg::i2c_req_t    op,
    input  logic                    op_ack,
    input  eeprom_pkg::i2c_rsp_t    op_rsp
);
    import eeprom_pkg::*;

    // one-hot main states
    localparam logic [9:0] IDLE    = 10'b00_0000_0001;
    localparam logic [9:0] START   = 10'b00_0000_0010;
    localparam logic [9:0] DEV_W   = 10'b00_0000_0100;
    localparam logic [9:0] ADDR    = 10'b00_0000_1000;
    localparam logic [9:0] DATA    = 10'b00_0001_0000;
    localparam logic [9:0] RSTART  = 10'b00_0010_0000;
    localparam logic [9:0] DEV_R   = 10'b00_0100_0000;
    localparam logic [9:0] RD_BYTE = 10'b00_1000_0000;
    localparam logic [9:0] STOP    = 10'b01_0000_0000;
    localparam logic [9:0] DONE    = 10'b10_0000_0000;

    logic [9:0]  state;
    logic [9:0]  next_state;
    eeprom_cmd_t cmd;
    i2c_req_t    req_c;
    logic [6:0]  dev_sel;       // device code plus block bits

    assign dev_sel = {DEVICE_CODE, cmd.addr[10:8]};

    // operation for the current state and where to go after it
    always_comb begin
        req_c      = '{op: OP_START, wdata: 8'h00, master_nack: 1'b0};
        next_state = STOP;
        case (state)
            START:  next_state = DEV_W;
            DEV_W: begin
                req_c.op    = OP_WRITE;
                req_c.wdata = {dev_sel, 1'b0};
                next_state  = ADDR;
            end
            ADDR: begin
                req_c.op    = OP_WRITE;
                req_c.wdata = cmd.addr[7:0];
                next_state  = cmd.write ? DATA : RSTART;
            end
            DATA: begin
                req_c.op    = OP_WRITE;
                req_c.wdata = cmd.wdata;
            end
            RSTART: next_state = DEV_R;
            DEV_R: begin
                req_c.op    = OP_WRITE;
                req_c.wdata = {dev_sel, 1'b1};
                next_state  = RD_BYTE;
            end
            RD_BYTE: begin
                req_c.op          = OP_READ;
                req_c.master_nack = 1'b1;   // single byte read
            end
            STOP: begin
                req_c.op   = OP_STOP;
                next_state = DONE;
            end
            default: next_state = STOP;
        endcase
        if (op_rsp.slave_nack)
            next_state = STOP;  // refused byte ends the transfer
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state          <= IDLE;
            host_ack       <= 1'b0;
            op_req         <= 1'b0;
            host_rsp.error <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (host_req && !host_ack) begin
                        cmd            <= host_cmd;
                        host_rsp.error <= 1'b0;
                        state          <= START;
                    end
                end
                START, DEV_W, ADDR, DATA, RSTART, DEV_R, RD_BYTE, STOP: begin
                    if (!op_req && !op_ack) begin
                        op_req <= 1'b1;
                        op     <= req_c;
                    end else if (op_req && op_ack) begin
                        op_req <= 1'b0;
                        state  <= next_state;
                        if (op_rsp.slave_nack)
                            host_rsp.error <= 1'b1;
                        if (state == RD_BYTE)
                            host_rsp.rdata <= op_rsp.rdata;
                    end
                end
                DONE: begin
                    if (!host_ack) begin
                        host_ack <= 1'b1;
                    end else if (!host_req) begin
                        host_ack <= 1'b0;
                        state    <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_cmd_stable: assert property (@(posedge CLK) disable iff (RESET)
        ($past(host_req && !host_ack) && host_req && !host_ack) |-> $stable(host_cmd));

    // engine handshake must return to zero first
    a_req_after_ack: assert property (@(posedge CLK) disable iff (RESET)
        $rose(op_req) |-> !op_ack);

endmodule

/* src/i2c_byte_engine.sv */
module i2c_byte_engine #(
    parameter int CLK_DIV = 2
) (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 op_req,
    input  eeprom_pkg::i2c_req_t op,
    input  logic                 sda_in,
    output logic                 op_ack,
    output eeprom_pkg::i2c_rsp_t op_rsp,
    output logic                 scl,
    output logic                 sda_oe
);
    import eeprom_pkg::*;

    localparam int QW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    // head, stop, shift-out and shift-in folded into one machine
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_START,
        PH_STOP,
        PH_SHOUT,
        PH_SHIN,
        PH_DONE
    } phase_t;

    phase_t        phase;
    logic [QW-1:0] qcnt;
    logic [1:0]    quarter;     // scl low in quarters 0 and 1
    logic [3:0]    bit_cnt;
    logic [7:0]    shreg;
    logic          nack_out;
    logic          ack_nack;
    logic          busy;
    logic          qtick;
    logic          drive_pt;
    logic          sample_pt;
    logic          last_bit;

    assign busy      = phase inside {PH_START, PH_STOP, PH_SHOUT, PH_SHIN};
    assign qtick     = busy && (qcnt == QW'(CLK_DIV - 1));
    assign drive_pt  = busy && (quarter == 2'd0) && (qcnt == '0);
    assign sample_pt = busy && (quarter == 2'd3) && (qcnt == '0);
    assign last_bit  = (phase inside {PH_START, PH_STOP}) || (bit_cnt == 4'd8);

    assign op_rsp = '{rdata: shreg, slave_nack: ack_nack};

    always_ff @(posedge CLK) begin
        if (RESET) begin
            qcnt    <= '0;
            quarter <= 2'd0;
        end else if (busy) begin
            if (qtick) begin
                qcnt    <= '0;
                quarter <= quarter + 2'd1;  // wraps to 0 at end of bit
            end else begin
                qcnt <= qcnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            phase   <= PH_IDLE;
            op_ack  <= 1'b0;
            scl     <= 1'b1;
            sda_oe  <= 1'b0;
            bit_cnt <= 4'd0;
        end else begin
            case (phase)
                PH_IDLE: begin
                    if (op_req && !op_ack) begin
                        scl      <= 1'b0;   // first quarter of the first bit
                        bit_cnt  <= 4'd0;
                        shreg    <= op.wdata;
                        nack_out <= op.master_nack;
                        ack_nack <= 1'b0;
                        case (op.op)
                            OP_START: phase <= PH_START;
                            OP_STOP:  phase <= PH_STOP;
                            OP_WRITE: phase <= PH_SHOUT;
                            OP_READ:  phase <= PH_SHIN;
                        endcase
                    end
                end
                PH_START, PH_STOP, PH_SHOUT, PH_SHIN: begin
                    if (drive_pt) begin
                        case (phase)
                            PH_START: sda_oe <= 1'b0;
                            PH_STOP:  sda_oe <= 1'b1;
                            PH_SHOUT: sda_oe <= (bit_cnt == 4'd8) ? 1'b0 : ~shreg[7];
                            default:  sda_oe <= (bit_cnt == 4'd8) ? ~nack_out : 1'b0;
                        endcase
                    end
                    if (sample_pt) begin
                        case (phase)
                            PH_START: sda_oe <= 1'b1;   // sda falls under high scl
                            PH_STOP:  sda_oe <= 1'b0;   // sda rises under high scl
                            default: begin
                                if (bit_cnt == 4'd8)
                                    ack_nack <= (phase == PH_SHOUT) && sda_in;
                                else
                                    shreg <= {shreg[6:0], sda_in};
                            end
                        endcase
                    end
                    if (qtick) begin
                        if (quarter == 2'd1) begin
                            scl <= 1'b1;
                        end else if (quarter == 2'd3) begin
                            if (last_bit) begin
                                phase  <= PH_DONE;      // scl left high
                                op_ack <= 1'b1;
                            end else begin
                                bit_cnt <= bit_cnt + 4'd1;
                                scl     <= 1'b0;
                            end
                        end
                    end
                end
                PH_DONE: begin
                    if (!op_req) begin
                        op_ack <= 1'b0;
                        phase  <= PH_IDLE;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    // data only moves under high scl when it is a start or stop
    a_sda_scl_high: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && $changed(sda_oe)) |-> ($past(phase) inside {PH_START, PH_STOP}));

    a_ack_needs_req: assert property (@(posedge CLK) disable iff (RESET)
        $rose(op_ack) |-> $past(op_req));

endmodule

/* src/eeprom_pkg.sv */
package eeprom_pkg;

    // 2 KB array with bits 10:8 riding in the device byte
    typedef logic [10:0] eeprom_addr_t;

    typedef struct packed {
        logic         write;    // 1 write, 0 read
        eeprom_addr_t addr;
        logic [7:0]   wdata;
    } eeprom_cmd_t;

    typedef struct packed {
        logic [7:0] rdata;
        logic       error;      // slave refused a byte
    } eeprom_rsp_t;

    // OP_START doubles as repeated start
    typedef enum logic [1:0] {
        OP_START,
        OP_STOP,
        OP_WRITE,
        OP_READ
    } i2c_op_t;

    typedef struct packed {
        i2c_op_t    op;
        logic [7:0] wdata;
        logic       master_nack;  // read only
    } i2c_req_t;

    typedef struct packed {
        logic [7:0] rdata;
        logic       slave_nack;
    } i2c_rsp_t;

    // fixed upper nibble of the device-select byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

endpackage
